/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* lsu_issue.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_issue (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              issue_valid_i,
   input  lsu_pkg::exec_in_t issue_i,
   input  logic              credit_i,
   output logic              stall_o,
   output logic              req_valid_o,
   output lsu_pkg::mem_req_t req_o
);

   import lsu_pkg::*;

   localparam logic [`LSU_CRW-1:0] CREDIT_INIT = `LSU_CRW'(`LSU_QDEPTH);

   logic [`LSU_CRW-1:0] credits;
   logic                accept;
   ir_type_e            ir_type;
   mem_op_e             dec_op;
   mem_size_e           dec_size;

   ////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      ir_type = ir_type_e'(issue_i.ir[31:28]);
      case (ir_type)
         T_LOAD:  dec_op = MOP_LOAD;
         T_STORE: dec_op = MOP_STORE;
         default: dec_op = MOP_NONE;   // ALU types pass through.
      endcase
      case (issue_i.ir[25:24])
         2'd1:    dec_size = SZ_HALF;
         2'd2:    dec_size = SZ_BYTE;
         default: dec_size = SZ_WORD;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Credits and request register
   ////////////////////////////////////////////////////////////

   assign stall_o = (credits == '0);             // Queue may be full.
   assign accept  = issue_valid_i & ~stall_o;

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         credits     <= CREDIT_INIT;
         req_valid_o <= 1'b0;
      end
      else
      begin
         req_valid_o <= accept;
         case ({accept, credit_i})
            2'b10:   credits <= credits - 1'b1;  // Send spends one.
            2'b01:   credits <= credits + 1'b1;  // Return from queue.
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         req_o.op        <= dec_op;
         req_o.size      <= dec_size;
         req_o.adr       <= issue_i.result;
         req_o.data      <= issue_i.data;
         req_o.reg_write <= issue_i.reg_write;
      end
   end

endmodule

/* lsu_mem.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_mem (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              q_valid_i,
   input  lsu_pkg::mem_req_t q_head_i,
   input  logic              bus_ack_i,
   input  logic [`LSU_DW-1:0] bus_dat_i,
   output logic              q_pop_o,
   output logic              bus_cyc_o,
   output logic              bus_we_o,
   output logic [31:0]       bus_adr_o,
   output logic [3:0]        bus_sel_o,
   output logic [`LSU_DW-1:0] bus_dat_o,
   output logic              wb_valid_o,
   output lsu_pkg::wb_t      wb_o
);

   import lsu_pkg::*;

   ms_state_e   state;
   mem_req_t    req_q;                         // Held for the whole bus cycle.
   logic        busy;
   logic        ack;
   logic [31:0] load_data;

   assign busy      = (state != MS_IDLE);
   assign ack       = busy & bus_ack_i;
   assign q_pop_o   = (state == MS_IDLE) & q_valid_i;
   assign bus_cyc_o = busy;
   assign bus_we_o  = (state == MS_STORE);
   assign bus_adr_o = req_q.adr;

   ////////////////////////////////////////////////////////////
   // Lanes, big-endian
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (req_q.size)
         SZ_HALF: bus_sel_o = req_q.adr[1] ? 4'b0011 : 4'b1100;
         SZ_BYTE:
            case (req_q.adr[1:0])
               2'b00:   bus_sel_o = 4'b1000;
               2'b01:   bus_sel_o = 4'b0100;
               2'b10:   bus_sel_o = 4'b0010;
               default: bus_sel_o = 4'b0001;
            endcase
         default: bus_sel_o = 4'b1111;
      endcase
   end

   always_comb
   begin
      case (req_q.size)
         SZ_HALF: bus_dat_o = {2{req_q.data[15:0]}};
         SZ_BYTE: bus_dat_o = {4{req_q.data[7:0]}};
         default: bus_dat_o = req_q.data;
      endcase
   end

   // Right-align the selected lanes, zero-extended.
   always_comb
   begin
      case (req_q.size)
         SZ_HALF:
            load_data = {16'h0, req_q.adr[1] ? bus_dat_i[15:0] : bus_dat_i[31:16]};
         SZ_BYTE:
            case (req_q.adr[1:0])
               2'b00:   load_data = {24'h0, bus_dat_i[31:24]};
               2'b01:   load_data = {24'h0, bus_dat_i[23:16]};
               2'b10:   load_data = {24'h0, bus_dat_i[15:8]};
               default: load_data = {24'h0, bus_dat_i[7:0]};
            endcase
         default: load_data = bus_dat_i;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state      <= MS_IDLE;
         wb_valid_o <= 1'b0;
      end
      else
      begin
         wb_valid_o <= 1'b0;
         case (state)
            MS_IDLE:
               if (q_pop_o)
               begin
                  case (q_head_i.op)
                     MOP_LOAD:  state <= MS_LOAD;
                     MOP_STORE: state <= MS_STORE;
                     default:   wb_valid_o <= 1'b1;   // No bus cycle.
                  endcase
               end
            MS_LOAD, MS_STORE:
               if (bus_ack_i)
               begin
                  state      <= MS_IDLE;
                  wb_valid_o <= 1'b1;
               end
            default: state <= MS_IDLE;
         endcase
      end
   end

   // Request latch and writeback record.
   always_ff @(posedge clk_i)
   begin
      if (q_pop_o)
         req_q <= q_head_i;
      if (q_pop_o && q_head_i.op == MOP_NONE)
      begin
         wb_o.result    <= q_head_i.adr;
         wb_o.reg_write <= q_head_i.reg_write;
         wb_o.op        <= q_head_i.op;
      end
      else if (ack)
      begin
         wb_o.result    <= (req_q.op == MOP_LOAD) ? load_data : req_q.adr;
         wb_o.reg_write <= req_q.reg_write;
         wb_o.op        <= req_q.op;
      end
   end

endmodule

/* lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

////////////////////////////////////////////////////////////
// Load/store path sizing
////////////////////////////////////////////////////////////

// Request queue entries, also the credits held after reset.
`define LSU_QDEPTH 4

// Credit counter width. Must hold the value LSU_QDEPTH.
`define LSU_CRW 3

////////////////////////////////////////////////////////////
// Bus
////////////////////////////////////////////////////////////

`define LSU_DW 32                     // Data bus width.

`endif

/* lsu_pkg.sv */
package lsu_pkg;

   ////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////

   // Bits 31:28 of the instruction word. Other codes are ALU types.
   typedef enum logic [3:0] {
      T_LOAD  = 4'h8,
      T_STORE = 4'h9
   } ir_type_e;

   typedef enum logic [1:0] {
      MOP_NONE  = 2'd0,
      MOP_LOAD  = 2'd1,
      MOP_STORE = 2'd2
   } mem_op_e;

   typedef enum logic [1:0] {
      SZ_WORD = 2'd0,
      SZ_HALF = 2'd1,
      SZ_BYTE = 2'd2
   } mem_size_e;

   typedef enum logic [1:0] {
      MS_IDLE  = 2'd0,
      MS_LOAD  = 2'd1,
      MS_STORE = 2'd2
   } ms_state_e;

   ////////////////////////////////////////////////////////////
   // Records
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [31:0] ir;                 // Instruction word.
      logic [31:0] result;             // ALU result or address.
      logic [31:0] data;               // Store data.
      logic [1:0]  reg_write;
   } exec_in_t;

   typedef struct packed {
      mem_op_e     op;
      mem_size_e   size;
      logic [31:0] adr;                // Result for MOP_NONE.
      logic [31:0] data;
      logic [1:0]  reg_write;
   } mem_req_t;

   typedef struct packed {
      logic [31:0] result;
      logic [1:0]  reg_write;
      mem_op_e     op;
   } wb_t;

endpackage

/* lsu_queue.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_queue (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              push_i,
   input  lsu_pkg::mem_req_t push_data_i,
   input  logic              pop_i,
   output logic              valid_o,
   output lsu_pkg::mem_req_t head_o,
   output logic              credit_o
);

   import lsu_pkg::*;

   localparam int unsigned   AW   = (`LSU_QDEPTH > 1) ? $clog2(`LSU_QDEPTH) : 1;
   localparam logic [AW-1:0] LAST = AW'(`LSU_QDEPTH - 1);

   mem_req_t      entries [`LSU_QDEPTH];
   logic [AW-1:0] rd_ptr;
   logic [AW-1:0] wr_ptr;
   logic [AW:0]   count;
   logic          pop;

   assign valid_o = (count != '0);
   assign head_o  = entries[rd_ptr];
   assign pop     = pop_i & valid_o;           // Ignore pop on empty.

   ////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         rd_ptr   <= '0;
         wr_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end
      else
      begin
         credit_o <= pop;                      // One credit per entry taken.
         if (push_i)
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
         case ({push_i, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage. The credit rule keeps pushes off a full queue.
   always_ff @(posedge clk_i)
   begin
      if (push_i)
         entries[wr_ptr] <= push_data_i;
   end

endmodule

/* lsu_sva.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_sva (
   input logic                clk_i,
   input logic                rst_i,
   input logic                issue_valid_i,
   input logic                stall_o,
   input logic                bus_cyc_o,
   input logic                bus_we_o,
   input logic [31:0]         bus_adr_o,
   input logic [3:0]          bus_sel_o,
   input logic [`LSU_DW-1:0]  bus_dat_o,
   input logic                bus_ack_i,
   input logic                wb_valid_o,
   input logic [`LSU_CRW-1:0] credits_i,
   input lsu_pkg::ms_state_e  state_i
);

   import lsu_pkg::*;

   int errors = 0;                             // Failed checks so far.
   int outstanding;                            // Accepted, not yet written back.

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
         outstanding <= 0;
      else
         outstanding <= outstanding + int'(issue_valid_i && !stall_o) - int'(wb_valid_o);
   end

   ////////////////////////////////////////////////////////////
   // Bus protocol
   ////////////////////////////////////////////////////////////

   bus_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_cyc_o && !bus_ack_i |=> bus_cyc_o && $stable(bus_we_o) && $stable(bus_adr_o)
         && $stable(bus_sel_o) && $stable(bus_dat_o))
   else begin $error("bus outputs changed before acknowledge"); errors++; end

   // The cycle ends with the acknowledge and the writeback follows.
   bus_end: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_cyc_o && bus_ack_i |=> state_i == MS_IDLE && wb_valid_o)
   else begin $error("no writeback or idle state after acknowledge"); errors++; end

   ////////////////////////////////////////////////////////////
   // Credits and reset
   ////////////////////////////////////////////////////////////

   in_flight: assert property (@(posedge clk_i) disable iff (rst_i)
      outstanding <= `LSU_QDEPTH + 2)
   else begin $error("too many instructions in flight"); errors++; end

   // Queue full and memory stage busy leaves no credit.
   stall_full: assert property (@(posedge clk_i) disable iff (rst_i)
      outstanding > `LSU_QDEPTH |-> credits_i == '0 && stall_o)
   else begin $error("credits left or no stall with the pipeline full"); errors++; end

   reset_quiet: assert property (@(posedge clk_i)
      rst_i || $fell(rst_i) |-> !stall_o && !bus_cyc_o && !wb_valid_o)
   else begin $error("outputs active around reset"); errors++; end

endmodule

bind lsu_top lsu_sva u_sva (
   .clk_i         (clk_i),
   .rst_i         (rst_i),
   .issue_valid_i (issue_valid_i),
   .stall_o       (stall_o),
   .bus_cyc_o     (bus_cyc_o),
   .bus_we_o      (bus_we_o),
   .bus_adr_o     (bus_adr_o),
   .bus_sel_o     (bus_sel_o),
   .bus_dat_o     (bus_dat_o),
   .bus_ack_i     (bus_ack_i),
   .wb_valid_o    (wb_valid_o),
   .credits_i     (u_issue.credits),
   .state_i       (u_mem.state)
);

/* lsu_top.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_top (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               issue_valid_i,
   input  lsu_pkg::exec_in_t  issue_i,
   output logic               stall_o,
   output logic               bus_cyc_o,
   output logic               bus_we_o,
   output logic [31:0]        bus_adr_o,
   output logic [3:0]         bus_sel_o,
   output logic [`LSU_DW-1:0] bus_dat_o,
   input  logic               bus_ack_i,
   input  logic [`LSU_DW-1:0] bus_dat_i,
   output logic               wb_valid_o,
   output lsu_pkg::wb_t       wb_o
);

   import lsu_pkg::*;

   logic     req_valid;
   mem_req_t req;
   logic     credit_ret;
   logic     q_valid;
   mem_req_t q_head;
   logic     q_pop;

   lsu_issue u_issue (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .issue_valid_i (issue_valid_i),
      .issue_i       (issue_i),
      .credit_i      (credit_ret),
      .stall_o       (stall_o),
      .req_valid_o   (req_valid),
      .req_o         (req)
   );

   lsu_queue u_queue (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (req_valid),
      .push_data_i (req),
      .pop_i       (q_pop),
      .valid_o     (q_valid),
      .head_o      (q_head),
      .credit_o    (credit_ret)
   );

   lsu_mem u_mem (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .q_valid_i  (q_valid),
      .q_head_i   (q_head),
      .bus_ack_i  (bus_ack_i),
      .bus_dat_i  (bus_dat_i),
      .q_pop_o    (q_pop),
      .bus_cyc_o  (bus_cyc_o),
      .bus_we_o   (bus_we_o),
      .bus_adr_o  (bus_adr_o),
      .bus_sel_o  (bus_sel_o),
      .bus_dat_o  (bus_dat_o),
      .wb_valid_o (wb_valid_o),
      .wb_o       (wb_o)
   );

endmodule

/* tb.f */
+incdir+.
lsu_pkg.sv
lsu_issue.sv
lsu_queue.sv
lsu_mem.sv
lsu_top.sv
lsu_sva.sv
tb_lsu.sv

/* tb_lsu.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module tb_lsu;

   import lsu_pkg::*;

   localparam int N_INSTR    = 200;
   localparam int MAX_CYCLES = N_INSTR * 8 + 100;

   typedef struct packed {
      logic        we;
      logic [31:0] adr;
      logic [3:0]  sel;
      logic [31:0] dat;
   } bus_op_t;

   logic               clk_i;
   logic               rst_i;
   logic               issue_valid_i;
   exec_in_t           issue_i;
   logic               stall_o;
   logic               bus_cyc_o;
   logic               bus_we_o;
   logic [31:0]        bus_adr_o;
   logic [3:0]         bus_sel_o;
   logic [`LSU_DW-1:0] bus_dat_o;
   logic               bus_ack_i;
   logic [`LSU_DW-1:0] bus_dat_i;
   logic               wb_valid_o;
   wb_t                wb_o;

   integer      seed;
   logic [31:0] mem [256];                     // Memory seen by the bus.
   logic [31:0] shadow [256];                  // Scoreboard copy.
   int          ack_delay [N_INSTR];
   wb_t         wb_q [$];
   bus_op_t     bus_q [$];
   int          n_wb;
   int          n_bus;
   int          cycles;
   int          stall_cycles;

   lsu_top u_dut (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   task automatic stop_run(input string why);
      if (why != "")
         $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic fail_value(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      stop_run("");
   endtask

   // Initial contents, distinct for each word.
   function automatic logic [31:0] fill_word(input int idx);
      logic [7:0] a;
      a = idx[7:0];
      return {a ^ 8'hC3, ~a, a, a ^ 8'h5A};
   endfunction

   task automatic random_instr(output exec_in_t ins);
      int kind;
      kind = $unsigned($random(seed)) % 3;
      ins.ir        = $random(seed);
      ins.data      = $random(seed);
      ins.reg_write = 2'($random(seed));
      ins.result    = $random(seed);
      if (kind == 0)
         ins.ir[31:28] = T_LOAD;
      else if (kind == 1)
         ins.ir[31:28] = T_STORE;
      else if (ins.ir[31:28] == T_LOAD || ins.ir[31:28] == T_STORE)
         ins.ir[31:28] = ins.ir[31:28] ^ 4'h4;  // Force an ALU code.
      if (kind != 2)
         ins.result = ins.result & 32'h0000_007F;  // 32 words, so loads hit stores.
   endtask

   ////////////////////////////////////////////////////////////
   // Scoreboard
   ////////////////////////////////////////////////////////////

   task automatic predict(input exec_in_t ins);
      wb_t         exp_wb;
      bus_op_t     exp_bus;
      int          n;
      int          off;
      int          shift;
      int          idx;
      logic [31:0] mask;
      n   = (ins.ir[25:24] == 2'd1) ? 2 : (ins.ir[25:24] == 2'd2) ? 1 : 4;
      off = 0;
      if (n == 2)
         off = ins.result[1] ? 2 : 0;
      else if (n == 1)
         off = int'(ins.result[1:0]);
      shift = (4 - off - n) * 8;               // Byte 0 is the top lane.
      mask  = (n == 4) ? 32'hFFFF_FFFF : ((32'h1 << (8 * n)) - 32'h1);
      idx   = int'(ins.result[9:2]);
      exp_wb.result    = ins.result;
      exp_wb.reg_write = ins.reg_write;
      exp_wb.op        = MOP_NONE;
      exp_bus.adr      = ins.result;
      exp_bus.sel      = 4'(((1 << n) - 1) << (4 - off - n));
      for (int b = 0; b < 4; b++)
         exp_bus.dat[8*b +: 8] = ins.data[8*(b % n) +: 8];   // Low bytes repeat upward.
      exp_bus.we       = (ins.ir[31:28] == T_STORE);
      if (ins.ir[31:28] == T_LOAD)
      begin
         exp_wb.op     = MOP_LOAD;
         exp_wb.result = (shadow[idx] >> shift) & mask;
         bus_q.push_back(exp_bus);
      end
      else if (ins.ir[31:28] == T_STORE)
      begin
         exp_wb.op   = MOP_STORE;
         shadow[idx] = (shadow[idx] & ~(mask << shift)) | ((ins.data & mask) << shift);
         bus_q.push_back(exp_bus);
      end
      wb_q.push_back(exp_wb);
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial
   begin
      exec_in_t ins;
      int       gap;
      seed          = 15086;
      rst_i         = 1'b1;
      issue_valid_i = 1'b0;
      issue_i       = '0;
      n_wb          = 0;
      n_bus         = 0;
      cycles        = 0;
      stall_cycles  = 0;
      for (int i = 0; i < 256; i++)
      begin
         mem[i]    = fill_word(i);
         shadow[i] = fill_word(i);
      end
      for (int i = 0; i < N_INSTR; i++)
         ack_delay[i] = $unsigned($random(seed)) % 6;
      repeat (5) @(posedge clk_i);
      #1 rst_i = 1'b0;
      for (int i = 0; i < N_INSTR; i++)
      begin
         gap = $unsigned($random(seed)) % 3;
         repeat (gap)
         begin
            @(posedge clk_i);
            #1;
         end
         random_instr(ins);
         issue_valid_i = 1'b1;
         issue_i       = ins;
         while (stall_o)
         begin
            stall_cycles++;
            @(posedge clk_i);
            #1;
         end
         predict(ins);                         // Taken at the next edge.
         @(posedge clk_i);
         #1 issue_valid_i = 1'b0;
      end
      while (n_wb < N_INSTR)
         @(posedge clk_i);
      repeat (3) @(posedge clk_i);
      if (bus_q.size() == 0 && stall_cycles > 0 && u_dut.u_sva.errors == 0)
      begin
         $display("TESTBENCH PASSED");
         $finish;
      end
      else
         stop_run("stall never reached, records left over or assertion failed");
   end

   ////////////////////////////////////////////////////////////
   // Memory model with random acknowledge delay
   ////////////////////////////////////////////////////////////

   initial
   begin
      bus_op_t exp_bus;
      int      wait_cnt;
      int      idx;
      logic    in_cycle;
      bus_ack_i = 1'b0;
      bus_dat_i = '0;
      in_cycle  = 1'b0;
      wait_cnt  = 0;
      forever
      begin
         @(posedge clk_i);
         #1 bus_ack_i = 1'b0;
         if (bus_cyc_o && !in_cycle)
         begin
            in_cycle = 1'b1;
            wait_cnt = ack_delay[n_bus % N_INSTR];
            n_bus++;
            assert (bus_q.size() > 0) else fail_value("bus cycle with no access expected");
            exp_bus = bus_q.pop_front();
            assert (bus_we_o == exp_bus.we && bus_adr_o == exp_bus.adr
                    && bus_sel_o == exp_bus.sel && (!exp_bus.we || bus_dat_o == exp_bus.dat))
            else fail_value($sformatf("bus we/adr/sel/dat %b %h %b %h, expected %b %h %b %h",
                                      bus_we_o, bus_adr_o, bus_sel_o, bus_dat_o, exp_bus.we,
                                      exp_bus.adr, exp_bus.sel, exp_bus.dat));
         end
         if (in_cycle && wait_cnt == 0)
         begin
            idx = int'(bus_adr_o[9:2]);
            if (bus_we_o)
            begin
               for (int b = 0; b < 4; b++)
                  if (bus_sel_o[b])
                     mem[idx][8*b +: 8] = bus_dat_o[8*b +: 8];
            end
            else
               bus_dat_i = mem[idx];
            bus_ack_i = 1'b1;
            in_cycle  = 1'b0;
         end
         else if (in_cycle)
            wait_cnt--;
      end
   end

   // Writeback check, assertion watch and timeout.
   initial
   begin
      wb_t exp_wb;
      forever
      begin
         @(posedge clk_i);
         #1 cycles++;
         if (cycles >= MAX_CYCLES)
            stop_run("timeout: writebacks missing");
         if (u_dut.u_sva.errors != 0)
            stop_run("a bus, credit or reset assertion failed");
         if (wb_valid_o)
         begin
            assert (wb_q.size() > 0) else fail_value("writeback with none expected");
            exp_wb = wb_q.pop_front();
            assert (wb_o == exp_wb)
            else fail_value($sformatf("writeback %0d got %h/%0d/%0d, expected %h/%0d/%0d",
                                      n_wb, wb_o.result, wb_o.reg_write, wb_o.op,
                                      exp_wb.result, exp_wb.reg_write, exp_wb.op));
            n_wb++;
         end
      end
   end

endmodule
